//--- hw/cache_pkg.sv
package cache_pkg;

    localparam int addr_width = 16;
    localparam int byte_bits = 8;
    localparam int line_bytes = 8;
    localparam int line_bits = line_bytes * byte_bits;
    localparam int num_sets = 64;

    // byte address = tag | index | offset.
    localparam int offset_bits = $clog2(line_bytes);
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits = addr_width - index_bits - offset_bits;

    typedef enum logic
    {
        op_load,
        op_store
    } cache_op_e;

    typedef enum logic [1:0]
    {
        refill_idle,
        refill_request,
        refill_wait,
        refill_write
    } refill_state_e;

endpackage

//--- hw/dual_port_blockram.sv
`timescale 1ns/100ps

module dual_port_blockram
#(
    parameter int entry_bits = 64,
    parameter int num_set = 64,
    parameter bit with_valid_array = 1'b1
)
(
    input  logic clk_in,
    input  logic reset_in,

    input  logic port_a_access_en,
    input  logic [(entry_bits + cache_pkg::byte_bits - 1) / cache_pkg::byte_bits - 1:0]
                 port_a_write_en,
    input  logic [$clog2(num_set)-1:0] port_a_addr,
    input  logic [entry_bits-1:0] port_a_write_entry,
    output logic [entry_bits-1:0] port_a_read_entry,
    output logic port_a_read_valid,

    input  logic port_b_access_en,
    input  logic [(entry_bits + cache_pkg::byte_bits - 1) / cache_pkg::byte_bits - 1:0]
                 port_b_write_en,
    input  logic [$clog2(num_set)-1:0] port_b_addr,
    input  logic [entry_bits-1:0] port_b_write_entry,
    output logic [entry_bits-1:0] port_b_read_entry,
    output logic port_b_read_valid
);

    import cache_pkg::*;

    logic [entry_bits-1:0] blockram [num_set];

    generate
        if (with_valid_array)
        begin : g_valid
            logic [num_set-1:0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array <= '0;
                    port_a_read_valid <= 1'b0;
                    port_b_read_valid <= 1'b0;
                end
                else
                begin
                    if (port_a_access_en && |port_a_write_en)
                    begin
                        valid_array[port_a_addr] <= 1'b1; // port A wins the bit.
                    end
                    if (port_b_access_en && |port_b_write_en &&
                        !(port_a_access_en && |port_a_write_en &&
                          port_a_addr == port_b_addr))
                    begin
                        valid_array[port_b_addr] <= 1'b1;
                    end
                    port_a_read_valid <= port_a_access_en && valid_array[port_a_addr];
                    port_b_read_valid <= port_b_access_en && valid_array[port_b_addr];
                end
            end
        end
        else
        begin : g_no_valid
            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    port_a_read_valid <= 1'b0;
                    port_b_read_valid <= 1'b0;
                end
                else
                begin
                    port_a_read_valid <= port_a_access_en; // every entry counts as valid.
                    port_b_read_valid <= port_b_access_en;
                end
            end
        end
    endgenerate

    // a write still returns the old entry.
    always @(posedge clk_in)
    begin
        if (port_a_access_en)
        begin
            for (int i = 0; i < entry_bits; i++)
            begin
                if (port_a_write_en[i / byte_bits])
                begin
                    blockram[port_a_addr][i] <= port_a_write_entry[i];
                end
            end
            port_a_read_entry <= blockram[port_a_addr];
        end
    end

    always @(posedge clk_in)
    begin
        if (port_b_access_en)
        begin
            for (int i = 0; i < entry_bits; i++)
            begin
                if (port_b_write_en[i / byte_bits])
                begin
                    blockram[port_b_addr][i] <= port_b_write_entry[i];
                end
            end
            port_b_read_entry <= blockram[port_b_addr];
        end
    end

    a_no_lane_collision: assert property (@(posedge clk_in) disable iff (reset_in)
        !(port_a_access_en && port_b_access_en && port_a_addr == port_b_addr &&
          |(port_a_write_en & port_b_write_en)));

endmodule

//--- hw/cache_lookup.sv
`timescale 1ns/100ps

module cache_lookup
(
    input  logic clk_in,
    input  logic reset_in,

    input  logic req_valid,
    input  cache_pkg::cache_op_e req_op,
    input  logic [cache_pkg::addr_width-1:0] req_addr,
    input  logic [cache_pkg::line_bytes-1:0] req_byte_en,
    input  logic [cache_pkg::line_bits-1:0] req_wdata,
    output logic req_ready,
    output logic resp_valid,
    output logic [cache_pkg::line_bits-1:0] resp_data,

    output logic mem_write_req,
    output logic [cache_pkg::addr_width-1:0] mem_write_addr,
    output logic [cache_pkg::line_bytes-1:0] mem_byte_en,
    output logic [cache_pkg::line_bits-1:0] mem_write_data,

    output logic ram_a_en,
    output logic [cache_pkg::index_bits-1:0] ram_a_index,
    input  logic [cache_pkg::tag_bits-1:0] tag_read,
    input  logic tag_read_valid,
    input  logic [cache_pkg::line_bits-1:0] data_read,

    output logic store_wr_en,
    output logic [cache_pkg::index_bits-1:0] store_index,
    output logic [cache_pkg::line_bytes-1:0] store_mask,
    output logic [cache_pkg::line_bits-1:0] store_data,

    output logic miss_start,
    output logic [cache_pkg::addr_width-1:0] miss_addr,
    input  logic refill_busy,
    input  logic refill_done,
    input  logic [cache_pkg::line_bits-1:0] refill_line
);

    import cache_pkg::*;

    logic accept;
    logic tag_hit;
    logic s2_valid;
    cache_op_e s2_op;
    logic [tag_bits-1:0] s2_tag;
    logic [index_bits-1:0] s2_index;
    logic [line_bytes-1:0] s2_mask;
    logic [line_bits-1:0] s2_wdata;
    logic fwd_valid;
    logic [index_bits-1:0] fwd_index;
    logic [line_bytes-1:0] fwd_mask;
    logic [line_bits-1:0] fwd_data;
    logic [line_bits-1:0] load_data;

    assign accept = req_valid && req_ready;
    assign ram_a_en = accept;
    assign ram_a_index = req_addr[offset_bits +: index_bits];

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            s2_valid <= 1'b0;
            s2_op <= op_load;
            fwd_valid <= 1'b0;
        end
        else
        begin
            s2_valid <= accept;
            if (accept)
            begin
                s2_op <= req_op;
            end
            fwd_valid <= store_wr_en;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            s2_tag <= req_addr[addr_width-1 -: tag_bits];
            s2_index <= req_addr[offset_bits +: index_bits];
            s2_mask <= req_byte_en;
            s2_wdata <= req_wdata;
        end
        if (store_wr_en)
        begin
            fwd_index <= s2_index; // ram still returns the old bytes next cycle.
            fwd_mask <= s2_mask;
            fwd_data <= s2_wdata;
        end
    end

    assign tag_hit = tag_read_valid && tag_read == s2_tag;

    always_comb
    begin
        load_data = data_read;
        if (fwd_valid && fwd_index == s2_index)
        begin
            for (int b = 0; b < line_bytes; b++)
            begin
                if (fwd_mask[b])
                begin
                    load_data[b*byte_bits +: byte_bits] = fwd_data[b*byte_bits +: byte_bits];
                end
            end
        end
    end

    assign miss_start = s2_valid && s2_op == op_load && !tag_hit;
    assign miss_addr = {s2_tag, s2_index, {offset_bits{1'b0}}};
    assign req_ready = !(miss_start || refill_busy); // held low through the refill.

    assign resp_valid = (s2_valid && (s2_op == op_store || tag_hit)) || refill_done;
    assign resp_data = refill_done ? refill_line : load_data;

    assign mem_write_req = s2_valid && s2_op == op_store; // stores always go through.
    assign mem_write_addr = {s2_tag, s2_index, {offset_bits{1'b0}}};
    assign mem_byte_en = s2_mask;
    assign mem_write_data = s2_wdata;

    assign store_wr_en = mem_write_req && tag_hit; // misses do not allocate.
    assign store_index = s2_index;
    assign store_mask = s2_mask;
    assign store_data = s2_wdata;

    a_no_resp_on_miss: assert property (@(posedge clk_in) disable iff (reset_in)
        miss_start |-> !resp_valid);

    a_stall_during_refill: assert property (@(posedge clk_in) disable iff (reset_in)
        refill_busy |-> !s2_valid);

endmodule

//--- hw/cache_refill.sv
`timescale 1ns/100ps

module cache_refill
(
    input  logic clk_in,
    input  logic reset_in,

    input  logic miss_start,
    input  logic [cache_pkg::addr_width-1:0] miss_addr,

    output logic mem_read_req,
    output logic [cache_pkg::addr_width-1:0] mem_read_addr,
    input  logic mem_read_valid,
    input  logic [cache_pkg::line_bits-1:0] mem_read_data,

    output logic fill_en,
    output logic [cache_pkg::index_bits-1:0] fill_index,
    output logic [cache_pkg::tag_bits-1:0] fill_tag,
    output logic [cache_pkg::line_bits-1:0] fill_line,

    output logic refill_busy,
    output logic refill_done,
    output logic [cache_pkg::line_bits-1:0] refill_line
);

    import cache_pkg::*;

    refill_state_e state;
    logic [tag_bits-1:0] miss_tag;
    logic [index_bits-1:0] miss_index;
    logic [line_bits-1:0] line_q;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= refill_idle;
        end
        else
        begin
            case (state)
                refill_idle:
                begin
                    if (miss_start)
                    begin
                        state <= refill_request;
                    end
                end
                refill_request:
                begin
                    state <= refill_wait;
                end
                refill_wait:
                begin
                    if (mem_read_valid)
                    begin
                        state <= refill_write; // latency is up to the memory.
                    end
                end
                default:
                begin
                    state <= refill_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (miss_start)
        begin
            miss_tag <= miss_addr[addr_width-1 -: tag_bits];
            miss_index <= miss_addr[offset_bits +: index_bits];
        end
        if (mem_read_valid)
        begin
            line_q <= mem_read_data;
        end
    end

    assign mem_read_req = state == refill_request;
    assign mem_read_addr = {miss_tag, miss_index, {offset_bits{1'b0}}};

    assign fill_en = state == refill_write;
    assign fill_index = miss_index;
    assign fill_tag = miss_tag;
    assign fill_line = line_q;

    assign refill_busy = state != refill_idle;
    assign refill_done = fill_en; // answer goes out as the line is written.
    assign refill_line = line_q;

    a_read_valid_in_wait: assert property (@(posedge clk_in) disable iff (reset_in)
        mem_read_valid |-> state == refill_wait);

endmodule

//--- hw/direct_mapped_cache.sv
`timescale 1ns/100ps

module direct_mapped_cache
(
    input  logic clk_in,
    input  logic reset_in,

    input  logic req_valid,
    input  cache_pkg::cache_op_e req_op,
    input  logic [cache_pkg::addr_width-1:0] req_addr,
    input  logic [cache_pkg::line_bytes-1:0] req_byte_en,
    input  logic [cache_pkg::line_bits-1:0] req_wdata,
    output logic req_ready,
    output logic resp_valid,
    output logic [cache_pkg::line_bits-1:0] resp_data,

    output logic mem_read_req,
    output logic [cache_pkg::addr_width-1:0] mem_addr,
    output logic mem_write_req,
    output logic [cache_pkg::line_bytes-1:0] mem_byte_en,
    output logic [cache_pkg::line_bits-1:0] mem_write_data,
    input  logic mem_read_valid,
    input  logic [cache_pkg::line_bits-1:0] mem_read_data
);

    import cache_pkg::*;

    logic ram_a_en;
    logic [index_bits-1:0] ram_a_index;
    logic [tag_bits-1:0] tag_read;
    logic tag_read_valid;
    logic [line_bits-1:0] data_read;
    logic store_wr_en;
    logic [index_bits-1:0] store_index;
    logic [line_bytes-1:0] store_mask;
    logic [line_bits-1:0] store_data;
    logic miss_start;
    logic [addr_width-1:0] miss_addr;
    logic refill_busy;
    logic refill_done;
    logic [line_bits-1:0] refill_line;
    logic fill_en;
    logic [index_bits-1:0] fill_index;
    logic [tag_bits-1:0] fill_tag;
    logic [line_bits-1:0] fill_line;
    logic [addr_width-1:0] write_addr;
    logic [addr_width-1:0] read_addr;
    logic data_b_en;
    logic [line_bytes-1:0] data_b_mask;
    logic [index_bits-1:0] data_b_index;
    logic [line_bits-1:0] data_b_entry;

    // refill owns data port B while busy, a store hit otherwise.
    assign data_b_en = refill_busy ? fill_en : store_wr_en;
    assign data_b_mask = refill_busy ? {line_bytes{1'b1}} : store_mask;
    assign data_b_index = refill_busy ? fill_index : store_index;
    assign data_b_entry = refill_busy ? fill_line : store_data;

    assign mem_addr = mem_read_req ? read_addr : write_addr;

    dual_port_blockram #(.entry_bits(tag_bits), .num_set(num_sets), .with_valid_array(1'b1))
    tag_ram
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .port_a_access_en(ram_a_en), .port_a_write_en(1'b0), .port_a_addr(ram_a_index),
        .port_a_write_entry('0), .port_a_read_entry(tag_read),
        .port_a_read_valid(tag_read_valid),
        .port_b_access_en(fill_en), .port_b_write_en(1'b1), .port_b_addr(fill_index),
        .port_b_write_entry(fill_tag), .port_b_read_entry(), .port_b_read_valid()
    );

    dual_port_blockram #(.entry_bits(line_bits), .num_set(num_sets), .with_valid_array(1'b0))
    data_ram
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .port_a_access_en(ram_a_en), .port_a_write_en('0), .port_a_addr(ram_a_index),
        .port_a_write_entry('0), .port_a_read_entry(data_read), .port_a_read_valid(),
        .port_b_access_en(data_b_en), .port_b_write_en(data_b_mask),
        .port_b_addr(data_b_index), .port_b_write_entry(data_b_entry),
        .port_b_read_entry(), .port_b_read_valid()
    );

    cache_lookup lookup0
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_byte_en(req_byte_en), .req_wdata(req_wdata), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_data(resp_data),
        .mem_write_req(mem_write_req), .mem_write_addr(write_addr),
        .mem_byte_en(mem_byte_en), .mem_write_data(mem_write_data),
        .ram_a_en(ram_a_en), .ram_a_index(ram_a_index), .tag_read(tag_read),
        .tag_read_valid(tag_read_valid), .data_read(data_read),
        .store_wr_en(store_wr_en), .store_index(store_index), .store_mask(store_mask),
        .store_data(store_data), .miss_start(miss_start), .miss_addr(miss_addr),
        .refill_busy(refill_busy), .refill_done(refill_done), .refill_line(refill_line)
    );

    cache_refill refill0
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .miss_start(miss_start), .miss_addr(miss_addr),
        .mem_read_req(mem_read_req), .mem_read_addr(read_addr),
        .mem_read_valid(mem_read_valid), .mem_read_data(mem_read_data),
        .fill_en(fill_en), .fill_index(fill_index), .fill_tag(fill_tag),
        .fill_line(fill_line), .refill_busy(refill_busy), .refill_done(refill_done),
        .refill_line(refill_line)
    );

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/100ps

module clock_gen
(
    output logic clk_in,
    output logic reset_in
);

    localparam int half_period = 20;
    localparam int reset_cycles = 3;
    localparam int drive_delay = 2;

    initial
    begin
        clk_in = 1'b0;
        forever
        begin
            #half_period clk_in = ~clk_in;
        end
    end

    initial
    begin
        reset_in = 1'b1;
        repeat (reset_cycles) @(posedge clk_in);
        #drive_delay reset_in = 1'b0; // released just after the third edge.
    end

endmodule

//--- dv/mem_model.sv
`timescale 1ns/100ps

module mem_model
(
    input  logic clk_in,
    input  logic reset_in,
    input  logic mem_read_req,
    input  logic [cache_pkg::addr_width-1:0] mem_addr,
    input  logic mem_write_req,
    input  logic [cache_pkg::line_bytes-1:0] mem_byte_en,
    input  logic [cache_pkg::line_bits-1:0] mem_write_data,
    output logic mem_read_valid,
    output logic [cache_pkg::line_bits-1:0] mem_read_data
);

    import cache_pkg::*;

    localparam int num_lines = 2 ** (addr_width - offset_bits);
    localparam int max_latency = 6;

    logic [line_bits-1:0] lines [num_lines];
    integer seed;
    logic busy;
    int unsigned wait_count;
    logic [addr_width-offset_bits-1:0] read_line;
    logic [addr_width-offset_bits-1:0] write_line;

    assign write_line = mem_addr[addr_width-1:offset_bits];

    initial
    begin
        seed = 32'h36c950b1;
        mem_read_valid = 1'b0;
        mem_read_data = '0;
        for (int i = 0; i < num_lines; i++)
        begin
            lines[i] = {$random(seed), $random(seed) ^ i}; // low word carries the line number.
        end
    end

    always @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            busy <= 1'b0;
            wait_count <= 0;
            mem_read_valid <= 1'b0;
        end
        else
        begin
            mem_read_valid <= 1'b0;
            if (mem_write_req)
            begin
                for (int b = 0; b < line_bytes; b++)
                begin
                    if (mem_byte_en[b])
                    begin
                        lines[write_line][b*byte_bits +: byte_bits] <=
                            mem_write_data[b*byte_bits +: byte_bits];
                    end
                end
            end
            if (mem_read_req)
            begin
                busy <= 1'b1;
                read_line <= mem_addr[addr_width-1:offset_bits];
                wait_count <= $unsigned($random(seed)) % max_latency; // 1 to 6 idle cycles.
            end
            else if (busy)
            begin
                if (wait_count == 0)
                begin
                    busy <= 1'b0;
                    mem_read_valid <= 1'b1;
                    mem_read_data <= lines[read_line];
                end
                else
                begin
                    wait_count <= wait_count - 1;
                end
            end
        end
    end

endmodule

//--- dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    import cache_pkg::*;

    localparam int drive_delay = 2;
    localparam int timeout_cycles = 50;
    localparam int mem_lines = 2 ** (addr_width - offset_bits);
    localparam int random_ops = 300;
    localparam int random_lines = 24;

    logic clk_in;
    logic reset_in;
    logic req_valid;
    cache_op_e req_op;
    logic [addr_width-1:0] req_addr;
    logic [line_bytes-1:0] req_byte_en;
    logic [line_bits-1:0] req_wdata;
    logic req_ready;
    logic resp_valid;
    logic [line_bits-1:0] resp_data;
    logic mem_read_req;
    logic [addr_width-1:0] mem_addr;
    logic mem_write_req;
    logic [line_bytes-1:0] mem_byte_en;
    logic [line_bits-1:0] mem_write_data;
    logic mem_read_valid;
    logic [line_bits-1:0] mem_read_data;

    logic [line_bits-1:0] golden [mem_lines];
    logic [line_bits-1:0] exp_line [$];
    logic exp_load [$];
    integer seed;
    int cycle = 0;
    int accept_cycle = 0;
    int resp_cycle = 0;
    int reads = 0;
    int writes = 0;
    int checks = 0;
    int errors = 0;
    int resp_count = 0;
    logic [addr_width-1:0] last_wr_addr;
    logic [line_bytes-1:0] last_wr_mask;
    logic [line_bits-1:0] last_wr_data;

    clock_gen clk0 (.clk_in(clk_in), .reset_in(reset_in));

    direct_mapped_cache dut0
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_byte_en(req_byte_en), .req_wdata(req_wdata), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_data(resp_data),
        .mem_read_req(mem_read_req), .mem_addr(mem_addr), .mem_write_req(mem_write_req),
        .mem_byte_en(mem_byte_en), .mem_write_data(mem_write_data),
        .mem_read_valid(mem_read_valid), .mem_read_data(mem_read_data)
    );

    mem_model mem0
    (
        .clk_in(clk_in), .reset_in(reset_in),
        .mem_read_req(mem_read_req), .mem_addr(mem_addr), .mem_write_req(mem_write_req),
        .mem_byte_en(mem_byte_en), .mem_write_data(mem_write_data),
        .mem_read_valid(mem_read_valid), .mem_read_data(mem_read_data)
    );

    always @(posedge clk_in)
    begin
        cycle <= cycle + 1;
    end

    // merges a store into the golden line, or returns it as is for a zero mask.
    function automatic logic [line_bits-1:0] golden_line(input logic [addr_width-1:0] addr,
            input logic [line_bytes-1:0] mask, input logic [line_bits-1:0] data);
        logic [line_bits-1:0] line;
        line = golden[addr[addr_width-1:offset_bits]];
        for (int b = 0; b < line_bytes; b++)
        begin
            if (mask[b])
            begin
                line[b*byte_bits +: byte_bits] = data[b*byte_bits +: byte_bits];
            end
        end
        return line;
    endfunction

    function automatic logic [addr_width-1:0] line_address(input int tag, input int index);
        return {tag[tag_bits-1:0], index[index_bits-1:0], {offset_bits{1'b0}}};
    endfunction

    task automatic check_value(input string name, input logic [line_bits-1:0] got,
                               input logic [line_bits-1:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic send_request(input cache_op_e op, input logic [addr_width-1:0] addr,
            input logic [line_bytes-1:0] mask, input logic [line_bits-1:0] data);
        int waited;
        logic [line_bits-1:0] expected;
        waited = 0;
        req_valid = 1'b1;
        req_op = op;
        req_addr = addr;
        req_byte_en = mask;
        req_wdata = data;
        @(negedge clk_in);
        while (!req_ready && waited < timeout_cycles)
        begin
            waited++;
            @(negedge clk_in);
        end
        if (!req_ready)
        begin
            $display("timeout at %0t: req_ready stayed low for %0d cycles", $time, waited);
            errors++;
            req_valid = 1'b0;
        end
        else
        begin
            @(posedge clk_in);
            #drive_delay;
            accept_cycle = cycle;
            req_valid = 1'b0;
            expected = golden_line(addr, (op == op_store) ? mask : '0, data);
            if (op == op_store)
            begin
                golden[addr[addr_width-1:offset_bits]] = expected; // memory always takes it.
            end
            exp_line.push_back(expected);
            exp_load.push_back(op == op_load);
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        @(posedge clk_in);
        while (exp_line.size() != 0 && waited < timeout_cycles)
        begin
            waited++;
            @(posedge clk_in);
        end
        if (exp_line.size() != 0)
        begin
            $display("timeout at %0t: %0d responses still missing after %0d cycles",
                     $time, exp_line.size(), waited);
            errors++;
            exp_line.delete();
            exp_load.delete();
        end
        #drive_delay;
    endtask

    task automatic report_test(input string name, input int errors_before);
        wait_responses();
        if (errors == errors_before)
        begin
            $display("test %s: passed", name);
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    always @(negedge clk_in)
    begin
        if (!reset_in && mem_read_req)
        begin
            reads++;
        end
        if (!reset_in && mem_write_req)
        begin
            writes++;
            last_wr_addr = mem_addr;
            last_wr_mask = mem_byte_en;
            last_wr_data = mem_write_data;
        end
    end

    always @(negedge clk_in)
    begin : compare
        logic [line_bits-1:0] expected;
        logic is_load;
        if (!reset_in && resp_valid)
        begin
            resp_cycle = cycle + 1; // counted at the edge that closes the response cycle.
            resp_count++;
            if (exp_line.size() == 0)
            begin
                $display("response at %0t arrived with no request outstanding", $time);
                errors++;
            end
            else
            begin
                expected = exp_line.pop_front();
                is_load = exp_load.pop_front();
                if (is_load)
                begin
                    checks++;
                    assert (resp_data === expected)
                    else
                    begin
                        $display("CHECK FAILED at %0t: resp_data got %h expected %h",
                                 $time, resp_data, expected);
                        errors++;
                    end
                end
            end
        end
    end

    initial
    begin : stimulus
        int waited;
        int mark;
        int reads_before;
        int writes_before;
        int sel;
        logic [31:0] rnd;
        logic [addr_width-1:0] addr;
        logic [addr_width-1:0] other;
        logic [line_bytes-1:0] mask;
        logic [line_bits-1:0] data;

        req_valid = 1'b0;
        req_op = op_load;
        req_addr = '0;
        req_byte_en = '0;
        req_wdata = '0;
        seed = 32'h36c950b1;
        waited = 0;

        @(posedge clk_in);
        while (reset_in && waited < timeout_cycles)
        begin
            waited++;
            @(posedge clk_in);
        end
        if (reset_in)
        begin
            $display("timeout at %0t: reset_in never fell", $time);
            errors++;
        end
        #drive_delay;
        for (int i = 0; i < mem_lines; i++)
        begin
            golden[i] = mem0.lines[i]; // start from the backing memory's fill.
        end

        mark = errors;
        @(negedge clk_in);
        check_value("req_ready", req_ready, 1);
        check_value("resp_valid", resp_valid, 0);
        check_value("mem_read_req", mem_read_req, 0);
        check_value("mem_write_req", mem_write_req, 0);
        @(posedge clk_in);
        #drive_delay;
        report_test("reset", mark);

        mark = errors;
        addr = line_address(0, 40);
        reads_before = reads;
        send_request(op_load, addr, '0, '0);
        wait_responses();
        check_value("mem_read_req pulses", reads - reads_before, 1);
        reads_before = reads;
        send_request(op_load, addr + 3, '0, '0);
        wait_responses();
        check_value("load hit latency", resp_cycle - accept_cycle, 1);
        check_value("mem_read_req pulses", reads - reads_before, 0);
        report_test("load miss then hit", mark);

        mark = errors;
        writes_before = writes;
        mask = 8'b1010_0101;
        data = {$random(seed), $random(seed)};
        send_request(op_store, addr + 5, mask, data);
        wait_responses();
        check_value("mem_write_req pulses", writes - writes_before, 1);
        check_value("mem_addr", last_wr_addr, addr);
        check_value("mem_byte_en", last_wr_mask, mask);
        check_value("mem_write_data", last_wr_data, data);
        check_value("store ack latency", resp_cycle - accept_cycle, 1);
        send_request(op_load, addr, '0, '0);
        report_test("byte-masked store hit", mark);

        mark = errors;
        reads_before = reads;
        send_request(op_store, addr, 8'h0f, {$random(seed), $random(seed)});
        send_request(op_load, addr, '0, '0);
        send_request(op_store, addr + 1, 8'hc2, {$random(seed), $random(seed)});
        send_request(op_load, addr + 7, '0, '0);
        wait_responses();
        check_value("mem_read_req pulses", reads - reads_before, 0);
        report_test("store then load forwarding", mark);

        mark = errors;
        addr = line_address(1, 1);
        other = line_address(17, 1);
        reads_before = reads;
        for (int k = 0; k < 4; k++)
        begin
            send_request(op_load, (k % 2 == 1) ? other : addr, '0, '0);
        end
        wait_responses();
        check_value("conflict mem_read_req pulses", reads - reads_before, 4);
        addr = line_address(34, 0);
        writes_before = writes;
        send_request(op_store, addr + 2, 8'h3c, {$random(seed), $random(seed)});
        wait_responses();
        check_value("store miss mem_write_req pulses", writes - writes_before, 1);
        reads_before = reads;
        send_request(op_load, addr, '0, '0);
        wait_responses();
        check_value("store miss no allocate", reads - reads_before, 1);
        report_test("conflict and store miss", mark);

        mark = errors;
        for (int n = 0; n < random_ops; n++)
        begin
            sel = $unsigned($random(seed)) % random_lines;
            rnd = $random(seed);
            addr = line_address(sel / 6, 8 + sel % 6); // four tags share six sets.
            addr[offset_bits-1:0] = rnd[offset_bits-1:0];
            data = {$random(seed), $random(seed)};
            if (rnd[8])
            begin
                send_request(op_store, addr, rnd[23:16], data);
            end
            else
            begin
                send_request(op_load, addr, '0, '0);
            end
        end
        report_test("random mix", mark);

        $display("summary: %0d checks, %0d responses, %0d reads, %0d writes, %0d errors",
                 checks, resp_count, reads, writes, errors);
        if (errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
hw/cache_pkg.sv
hw/dual_port_blockram.sv
hw/cache_lookup.sv
hw/cache_refill.sv
hw/direct_mapped_cache.sv
dv/clock_gen.sv
dv/mem_model.sv
dv/cache_tb.sv

//--- Bender.yml
package:
  name: direct_mapped_cache

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/dual_port_blockram.sv
      - hw/cache_lookup.sv
      - hw/cache_refill.sv
      - hw/direct_mapped_cache.sv
  - target: test
    files:
      - dv/clock_gen.sv
      - dv/mem_model.sv
      - dv/cache_tb.sv
